// File: logic_core.f
+incdir+verilog
+incdir+verif
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/reg_read_if.sv
verilog/fetch_port.sv
verilog/inst_decoder.sv
verilog/register_file.sv
verilog/operand_select.sv
verilog/logic_alu.sv
verilog/logic_core_top.sv
verif/logic_core_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f logic_core.f --top-module logic_core_tb \
        -o logic_core_sim \
    && ./obj_dir/logic_core_sim | tee /dev/stderr | grep -q "TEST PASSED" \
    || { echo "Simulation did not pass"; exit 1; }

// File: verif/logic_core_tb_tasks.svh
`ifndef LOGIC_CORE_TB_TASKS_SVH
`define LOGIC_CORE_TB_TASKS_SVH

function automatic logic [`INST_WIDTH-1:0] encode_special(
    input logic [`REG_ADDR_WIDTH-1:0]    rs,
    input logic [`REG_ADDR_WIDTH-1:0]    rt,
    input logic [`REG_ADDR_WIDTH-1:0]    rd,
    input logic [4:0]                    shamt,
    input logic [5:0]                    funct
);
    return {6'b000000, rs, rt, rd, shamt, funct};
endfunction

function automatic logic [`INST_WIDTH-1:0] encode_imm(
    input logic [5:0]                    opcode,
    input logic [`REG_ADDR_WIDTH-1:0]    rs,
    input logic [`REG_ADDR_WIDTH-1:0]    rt,
    input logic [`IMM_WIDTH-1:0]         imm
);
    return {opcode, rs, rt, imm};
endfunction

// Waits edge by edge until inst_ack reaches the given level
task automatic wait_ack_level(input logic level);
    logic seen;
    seen = 1'b0;
    for (int c = 0; c < TIMEOUT_CYCLES && !seen; c++) begin
        @(posedge clk);
        seen = (inst_ack === level);
    end
    if (!seen) begin
        stop_on_error($sformatf("Timeout: inst_ack did not go to %0b within %0d cycles",
                                level, TIMEOUT_CYCLES));
    end
endtask

// One full four-phase transfer, with the expected write-back set up alongside
task automatic issue_instruction(input logic [`INST_WIDTH-1:0] inst);
    logic                          we;
    logic [`REG_ADDR_WIDTH-1:0]    addr;
    logic [`DATA_WIDTH-1:0]        data;
    predict(inst, we, addr, data);
    instruction <= inst;
    inst_req    <= 1'b1;
    exp_we      <= we;
    exp_addr    <= addr;
    exp_data    <= data;
    wait_ack_level(1'b1);
    inst_req <= 1'b0;
    wait_ack_level(1'b0);  // Next request may start at this same edge
endtask

function automatic logic [`REG_ADDR_WIDTH-1:0] random_reg();
    logic [31:0] value;
    value = $random(seed);
    return value[`REG_ADDR_WIDTH-1:0];
endfunction

function automatic logic [`IMM_WIDTH-1:0] random_imm();
    logic [31:0] value;
    value = $random(seed);
    return value[`IMM_WIDTH-1:0];
endfunction

`endif

// File: verif/logic_core_tb.sv
`timescale 1ns/1ns
`include "logic_core_defines.svh"

module logic_core_tb;

    localparam int         TIMEOUT_CYCLES = 16;
    localparam logic [5:0] OPC_ANDI = 6'h0c;
    localparam logic [5:0] OPC_ORI  = 6'h0d;
    localparam logic [5:0] OPC_XORI = 6'h0e;
    localparam logic [5:0] OPC_LUI  = 6'h0f;
    localparam logic [5:0] FN_SLL   = 6'h00;
    localparam logic [5:0] FN_SRL   = 6'h02;
    localparam logic [5:0] FN_SRA   = 6'h03;
    localparam logic [5:0] FN_SLLV  = 6'h04;
    localparam logic [5:0] FN_SRLV  = 6'h06;
    localparam logic [5:0] FN_SRAV  = 6'h07;
    localparam logic [5:0] FN_AND   = 6'h24;
    localparam logic [5:0] FN_OR    = 6'h25;
    localparam logic [5:0] FN_XOR   = 6'h26;
    localparam logic [5:0] FN_NOR   = 6'h27;
    localparam logic [3:0][5:0] IMM_OPS      = {OPC_LUI, OPC_XORI, OPC_ORI, OPC_ANDI};
    localparam logic [3:0][5:0] LOGIC_FNS    = {FN_NOR, FN_XOR, FN_AND, FN_OR};
    localparam logic [2:0][5:0] FIXED_SHIFTS = {FN_SRA, FN_SRL, FN_SLL};
    localparam logic [2:0][5:0] VAR_SHIFTS   = {FN_SRAV, FN_SRLV, FN_SLLV};

    logic                          clk = 1'b0;
    logic                          reset;
    logic                          inst_req;
    logic                          inst_ack;
    logic [`INST_WIDTH-1:0]        instruction;
    logic                          wb_valid;
    logic [`REG_ADDR_WIDTH-1:0]    wb_addr;
    logic [`DATA_WIDTH-1:0]        wb_data;

    integer                        seed = 32'hbff5cf7c;
    string                         test_name = "reset";
    logic [`DATA_WIDTH-1:0]        model_regs [`REG_COUNT];
    logic                          exp_we;
    logic [`REG_ADDR_WIDTH-1:0]    exp_addr;
    logic [`DATA_WIDTH-1:0]        exp_data;
    logic                          req_q;
    logic [2:0]                    exp_valid_q;
    logic [2:0][`REG_ADDR_WIDTH-1:0] exp_addr_q;
    logic [2:0][`DATA_WIDTH-1:0]   exp_data_q;
    logic                          exp_wb_valid;
    logic [`REG_ADDR_WIDTH-1:0]    exp_wb_addr;
    logic [`DATA_WIDTH-1:0]        exp_wb_data;

    always #4 clk = ~clk;

    logic_core_top u_logic_core_top (.clk, .reset, .inst_req, .inst_ack, .instruction,
                                     .wb_valid, .wb_addr, .wb_data);

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "Stopping at the first error");
    endtask

    // Shadow of the architectural state, one instruction at a time
    function automatic void predict(input logic [`INST_WIDTH-1:0] inst, output logic we,
                                    output logic [`REG_ADDR_WIDTH-1:0] addr,
                                    output logic [`DATA_WIDTH-1:0] data);
        logic [5:0]             opc;
        logic [5:0]             fn;
        logic [4:0]             sa;
        logic [`DATA_WIDTH-1:0] a;
        logic [`DATA_WIDTH-1:0] b;
        opc  = inst[31:26];
        fn   = inst[5:0];
        sa   = inst[10:6];
        a    = model_regs[inst[25:21]];
        b    = model_regs[inst[20:16]];
        we   = 1'b1;
        addr = inst[15:11];
        data = '0;
        if (opc == 6'h00) begin
            case (fn)
                FN_SLL:  data = b << sa;
                FN_SRL:  data = b >> sa;
                FN_SRA:  data = $signed(b) >>> sa;
                FN_SLLV: data = b << a[4:0];
                FN_SRLV: data = b >> a[4:0];
                FN_SRAV: data = $signed(b) >>> a[4:0];
                FN_AND:  data = a & b;
                FN_OR:   data = a | b;
                FN_XOR:  data = a ^ b;
                FN_NOR:  data = ~(a | b);
                default: we = 1'b0;
            endcase
            if (fn inside {FN_SLL, FN_SRL, FN_SRA}) begin
                we = we && inst[25:21] == 5'd0;
            end else begin
                we = we && sa == 5'd0;
            end
        end else begin
            addr = inst[20:16];  // Immediate forms write rt
            case (opc)
                OPC_ANDI: data = a & {16'h0000, inst[15:0]};
                OPC_ORI:  data = a | {16'h0000, inst[15:0]};
                OPC_XORI: data = a ^ {16'h0000, inst[15:0]};
                OPC_LUI:  data = {inst[15:0], 16'h0000};
                default:  we = 1'b0;
            endcase
        end
        if (we && addr != '0) begin
            model_regs[addr] = data;
        end
    endfunction

    `include "logic_core_tb_tasks.svh"

    // A request is only raised while inst_ack is low, so its first edge is the acceptance
    always @(posedge clk) begin
        req_q <= inst_req;
        if (reset) begin
            exp_valid_q <= '0;
        end else begin
            exp_valid_q <= {exp_valid_q[1:0], inst_req && !req_q && exp_we};
        end
        exp_addr_q <= {exp_addr_q[1:0], exp_addr};
        exp_data_q <= {exp_data_q[1:0], exp_data};
    end

    assign exp_wb_valid = exp_valid_q[2];
    assign exp_wb_addr  = exp_addr_q[2];
    assign exp_wb_data  = exp_data_q[2];

    a_reset_quiet: assert property (@(posedge clk) $past(reset) |-> !inst_ack && !wb_valid)
        else stop_on_error("inst_ack or wb_valid was high right after a reset cycle");

    a_ack_rise: assert property (@(posedge clk) disable iff (reset)
                                 $rose(inst_ack) |-> $past(inst_req))
        else stop_on_error("inst_ack rose although inst_req was low");

    a_ack_fall: assert property (@(posedge clk) disable iff (reset)
                                 $fell(inst_ack) |-> !$past(inst_req))
        else stop_on_error("inst_ack fell although inst_req was still high");

    a_wb_valid: assert property (@(posedge clk) disable iff (reset) wb_valid == exp_wb_valid)
        else stop_on_error($sformatf("FAILED %s wb_valid: expected %0b actual %0b", test_name,
                                     $sampled(exp_wb_valid), $sampled(wb_valid)));

    a_wb_addr: assert property (@(posedge clk) disable iff (reset)
                                wb_valid |-> wb_addr == exp_wb_addr)
        else stop_on_error($sformatf("FAILED %s wb_addr: expected %0d actual %0d", test_name,
                                     $sampled(exp_wb_addr), $sampled(wb_addr)));

    a_wb_data: assert property (@(posedge clk) disable iff (reset)
                                wb_valid |-> wb_data == exp_wb_data)
        else stop_on_error($sformatf("FAILED %s wb_data: expected %h actual %h", test_name,
                                     $sampled(exp_wb_data), $sampled(wb_data)));

    initial begin
        logic [`REG_ADDR_WIDTH-1:0] pick;
        logic [`REG_ADDR_WIDTH-1:0] src;
        logic [`REG_ADDR_WIDTH-1:0] dest;
        reset       = 1'b1;
        inst_req    = 1'b0;
        instruction = '0;
        exp_we      = 1'b0;
        exp_addr    = '0;
        exp_data    = '0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            model_regs[i] = '0;
        end
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        test_name = "imm_load";
        for (int r = 1; r < `REG_COUNT; r++) begin
            issue_instruction(encode_imm(OPC_LUI, 5'd0, 5'(r), random_imm()));
            issue_instruction(encode_imm(OPC_ORI, 5'(r), 5'(r), random_imm()));
        end
        for (int i = 0; i < 16; i++) begin
            pick = random_reg();
            issue_instruction(encode_imm(IMM_OPS[pick[1:0]], random_reg(), random_reg(),
                                         random_imm()));
        end

        test_name = "logic_reg";
        for (int i = 0; i < 24; i++) begin
            issue_instruction(encode_special(random_reg(), random_reg(), random_reg(), 5'd0,
                                             LOGIC_FNS[i[1:0]]));
        end

        test_name = "shift";
        for (int k = 0; k < 3; k++) begin
            issue_instruction(encode_imm(OPC_LUI, 5'd0, 5'd7, 16'hf00d));  // Negative source
            issue_instruction(encode_special(5'd0, 5'd7, random_reg(), random_reg(),
                                             FIXED_SHIFTS[k]));
            issue_instruction(encode_special(random_reg(), 5'd7, random_reg(), 5'd0,
                                             VAR_SHIFTS[k]));
            for (int n = 0; n < 4; n++) begin
                issue_instruction(encode_special(5'd0, random_reg(), random_reg(),
                                                 random_reg(), FIXED_SHIFTS[k]));
                issue_instruction(encode_special(random_reg(), random_reg(), random_reg(),
                                                 5'd0, VAR_SHIFTS[k]));
            end
        end

        test_name = "forward_chain";
        dest = random_reg();
        for (int i = 0; i < 16; i++) begin
            src  = dest;
            dest = random_reg();
            if (i[0]) begin
                issue_instruction(encode_imm(OPC_XORI, src, dest, random_imm()));
            end else begin
                issue_instruction(encode_special(src, random_reg(), dest, 5'd0,
                                                 LOGIC_FNS[i[2:1]]));
            end
        end

        test_name = "invalid";
        issue_instruction(encode_imm(6'h23, 5'd4, 5'd5, random_imm()));
        issue_instruction(encode_special(5'd4, 5'd5, 5'd6, 5'd0, 6'h20));
        issue_instruction(encode_special(5'd3, 5'd5, 5'd6, 5'd4, FN_SLL));
        issue_instruction(encode_special(5'd4, 5'd5, 5'd6, 5'd2, FN_OR));

        test_name = "reg_zero";
        issue_instruction(encode_imm(OPC_ORI, 5'd5, 5'd0, 16'hbeef));
        issue_instruction(encode_special(5'd0, 5'd0, 5'd9, 5'd0, FN_OR));
        issue_instruction(encode_special(5'd0, 5'd6, 5'd10, 5'd0, FN_XOR));

        repeat (4) @(posedge clk);  // Covers the last write-back slot
        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: verilog/fetch_port.sv
`timescale 1ns/1ns
`include "logic_core_defines.svh"

module fetch_port (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       inst_req,
    output logic                       inst_ack,
    input  logic [`INST_WIDTH-1:0]     instruction,
    output logic                       id_valid,
    output logic [`INST_WIDTH-1:0]     id_instruction
);

    logic accept;

    assign accept = inst_req && !inst_ack;  // New request seen while idle

    always_ff @(posedge clk) begin
        if (reset) begin
            inst_ack <= 1'b0;
            id_valid <= 1'b0;
        end else begin
            id_valid <= accept;  // One cycle per accepted request
            if (accept) begin
                inst_ack <= 1'b1;
            end else if (!inst_req) begin
                inst_ack <= 1'b0;  // Requester has withdrawn
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            id_instruction <= instruction;
        end
    end

endmodule

// File: verilog/inst_decoder.sv
`timescale 1ns/1ns
`include "logic_core_defines.svh"

module inst_decoder (
    input  logic                           id_valid,
    input  logic [`INST_WIDTH-1:0]         id_instruction,
    reg_read_if.decoder                    rd,
    output isa_pkg::alu_op_t               op,
    output logic [`DATA_WIDTH-1:0]         imm,
    output logic                           write_enable,
    output logic [`REG_ADDR_WIDTH-1:0]     write_addr
);

    isa_pkg::opcode_t              opcode;
    isa_pkg::funct_t               funct;
    logic [`REG_ADDR_WIDTH-1:0]    rs_field;
    logic [`REG_ADDR_WIDTH-1:0]    rt_field;
    logic [`REG_ADDR_WIDTH-1:0]    rd_field;
    logic [`REG_ADDR_WIDTH-1:0]    shamt;
    logic [`IMM_WIDTH-1:0]         imm_field;
    logic                          fixed_shift;

    function automatic isa_pkg::alu_op_t special_op(input isa_pkg::funct_t f);
        case (f)
            isa_pkg::F_OR:                   return isa_pkg::ALU_OR;
            isa_pkg::F_AND:                  return isa_pkg::ALU_AND;
            isa_pkg::F_XOR:                  return isa_pkg::ALU_XOR;
            isa_pkg::F_NOR:                  return isa_pkg::ALU_NOR;
            isa_pkg::F_SLL, isa_pkg::F_SLLV: return isa_pkg::ALU_SLL;
            isa_pkg::F_SRL, isa_pkg::F_SRLV: return isa_pkg::ALU_SRL;
            isa_pkg::F_SRA, isa_pkg::F_SRAV: return isa_pkg::ALU_SRA;
            default:                         return isa_pkg::ALU_NOP;
        endcase
    endfunction

    assign opcode      = isa_pkg::opcode_t'(id_instruction[`OP_MSB:`OP_LSB]);
    assign funct       = isa_pkg::funct_t'(id_instruction[`FUNCT_MSB:`FUNCT_LSB]);
    assign rs_field    = id_instruction[`RS_MSB:`RS_LSB];
    assign rt_field    = id_instruction[`RT_MSB:`RT_LSB];
    assign rd_field    = id_instruction[`RD_MSB:`RD_LSB];
    assign shamt       = id_instruction[`SHAMT_MSB:`SHAMT_LSB];
    assign imm_field   = id_instruction[`IMM_WIDTH-1:0];
    assign fixed_shift = funct inside {isa_pkg::F_SLL, isa_pkg::F_SRL, isa_pkg::F_SRA};

    assign rd.read_addr1 = rs_field;
    assign rd.read_addr2 = rt_field;

    always_comb begin
        op              = isa_pkg::ALU_NOP;
        imm             = '0;
        write_enable    = 1'b0;
        write_addr      = rd_field;
        rd.read_enable1 = 1'b0;
        rd.read_enable2 = 1'b0;
        if (id_valid) begin
            case (opcode)
                isa_pkg::OP_SPECIAL: begin
                    // Fixed shifts need rs zero, the others need shamt zero
                    if (fixed_shift && rs_field == '0) begin
                        op              = special_op(funct);
                        write_enable    = 1'b1;
                        rd.read_enable2 = 1'b1;
                        imm = {{(`DATA_WIDTH-`REG_ADDR_WIDTH){1'b0}}, shamt};
                    end else if (!fixed_shift && shamt == '0 &&
                                 special_op(funct) != isa_pkg::ALU_NOP) begin
                        op              = special_op(funct);
                        write_enable    = 1'b1;
                        rd.read_enable1 = 1'b1;
                        rd.read_enable2 = 1'b1;
                    end
                end
                isa_pkg::OP_ORI, isa_pkg::OP_ANDI, isa_pkg::OP_XORI: begin
                    op = (opcode == isa_pkg::OP_ORI)  ? isa_pkg::ALU_OR  :
                         (opcode == isa_pkg::OP_ANDI) ? isa_pkg::ALU_AND : isa_pkg::ALU_XOR;
                    write_enable    = 1'b1;
                    write_addr      = rt_field;
                    rd.read_enable1 = 1'b1;
                    imm = {{(`DATA_WIDTH-`IMM_WIDTH){1'b0}}, imm_field};
                end
                isa_pkg::OP_LUI: begin
                    op           = isa_pkg::ALU_LUI;
                    write_enable = 1'b1;
                    write_addr   = rt_field;
                    imm = {imm_field, {(`DATA_WIDTH-`IMM_WIDTH){1'b0}}};
                end
                default: begin
                end
            endcase
        end
    end

endmodule

// File: verilog/isa_pkg.sv
package isa_pkg;

    // Major opcodes that the core accepts
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111
    } opcode_t;

    // Function codes under OP_SPECIAL
    typedef enum logic [5:0] {
        F_SLL  = 6'b000000,
        F_SRL  = 6'b000010,
        F_SRA  = 6'b000011,
        F_SLLV = 6'b000100,
        F_SRLV = 6'b000110,
        F_SRAV = 6'b000111,
        F_AND  = 6'b100100,
        F_OR   = 6'b100101,
        F_XOR  = 6'b100110,
        F_NOR  = 6'b100111
    } funct_t;

    // Immediate and variable shift forms share these operators
    typedef enum logic [3:0] {
        ALU_NOP,
        ALU_OR,
        ALU_AND,
        ALU_XOR,
        ALU_NOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_t;

endpackage

// File: verilog/logic_alu.sv
`timescale 1ns/1ns
`include "logic_core_defines.svh"

module logic_alu (
    input  logic                   clk,
    input  logic                   reset,
    input  pipe_pkg::exec_req_t    req,
    output pipe_pkg::write_port_t  ex_write,
    output pipe_pkg::write_port_t  mem_write
);

    localparam int SHIFT_WIDTH = $clog2(`DATA_WIDTH);

    logic [`DATA_WIDTH-1:0] result;
    logic [SHIFT_WIDTH-1:0] shift;
    logic                   writes;

    assign shift  = req.operand1[SHIFT_WIDTH-1:0];  // Shamt or rs value, low bits only
    assign writes = req.valid && req.write_enable && req.op != isa_pkg::ALU_NOP;

    always_comb begin
        case (req.op)
            isa_pkg::ALU_OR:  result = req.operand1 | req.operand2;
            isa_pkg::ALU_AND: result = req.operand1 & req.operand2;
            isa_pkg::ALU_XOR: result = req.operand1 ^ req.operand2;
            isa_pkg::ALU_NOR: result = ~(req.operand1 | req.operand2);
            isa_pkg::ALU_SLL: result = req.operand2 << shift;
            isa_pkg::ALU_SRL: result = req.operand2 >> shift;
            isa_pkg::ALU_SRA: result = $signed(req.operand2) >>> shift;
            isa_pkg::ALU_LUI: result = req.operand2;  // Immediate already sits in the upper half
            default:          result = '0;
        endcase
    end

    // Ex stage loads the new result while mem takes the previous one
    always_ff @(posedge clk) begin
        ex_write.addr  <= req.write_addr;
        ex_write.data  <= result;
        mem_write.addr <= ex_write.addr;
        mem_write.data <= ex_write.data;
        if (reset) begin
            ex_write.enable  <= 1'b0;
            mem_write.enable <= 1'b0;
        end else begin
            ex_write.enable  <= writes;
            mem_write.enable <= ex_write.enable;
        end
    end

endmodule

// File: verilog/logic_core_defines.svh
`ifndef LOGIC_CORE_DEFINES_SVH
`define LOGIC_CORE_DEFINES_SVH

`define DATA_WIDTH      32
`define REG_COUNT       32
`define REG_ADDR_WIDTH  5
`define INST_WIDTH      32

// Instruction field positions
`define OP_MSB          31
`define OP_LSB          26
`define RS_MSB          25
`define RS_LSB          21
`define RT_MSB          20
`define RT_LSB          16
`define RD_MSB          15
`define RD_LSB          11
`define SHAMT_MSB       10
`define SHAMT_LSB       6
`define FUNCT_MSB       5
`define FUNCT_LSB       0
`define IMM_WIDTH       16

`endif

// File: verilog/logic_core_top.sv
`timescale 1ns/1ns
`include "logic_core_defines.svh"

module logic_core_top (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           inst_req,
    output logic                           inst_ack,
    input  logic [`INST_WIDTH-1:0]         instruction,
    output logic                           wb_valid,
    output logic [`REG_ADDR_WIDTH-1:0]     wb_addr,
    output logic [`DATA_WIDTH-1:0]         wb_data
);

    logic                          id_valid;
    logic [`INST_WIDTH-1:0]        id_instruction;
    isa_pkg::alu_op_t              op;
    logic [`DATA_WIDTH-1:0]        imm;
    logic                          write_enable;
    logic [`REG_ADDR_WIDTH-1:0]    write_addr;
    logic [`DATA_WIDTH-1:0]        operand1;
    logic [`DATA_WIDTH-1:0]        operand2;
    pipe_pkg::exec_req_t           exec_req;
    pipe_pkg::write_port_t         ex_write;
    pipe_pkg::write_port_t         mem_write;

    reg_read_if read_if ();

    fetch_port u_fetch_port (.clk, .reset, .inst_req, .inst_ack, .instruction,
                             .id_valid, .id_instruction);

    inst_decoder u_inst_decoder (.id_valid, .id_instruction, .rd(read_if.decoder),
                                 .op, .imm, .write_enable, .write_addr);

    register_file u_register_file (.clk, .reset, .rd(read_if.file), .wr(mem_write));

    operand_select u_operand_select (.rd(read_if.select), .imm, .ex_write, .mem_write,
                                     .operand1, .operand2);

    assign exec_req = '{valid: id_valid, op: op, operand1: operand1, operand2: operand2,
                        write_enable: write_enable, write_addr: write_addr};

    logic_alu u_logic_alu (.clk, .reset, .req(exec_req), .ex_write, .mem_write);

    assign wb_valid = mem_write.enable;  // Same cycle the file sees the write
    assign wb_addr  = mem_write.addr;
    assign wb_data  = mem_write.data;

endmodule

// File: verilog/operand_select.sv
`timescale 1ns/1ns
`include "logic_core_defines.svh"

module operand_select (
    reg_read_if.select                 rd,
    input  logic [`DATA_WIDTH-1:0]     imm,
    input  pipe_pkg::write_port_t      ex_write,
    input  pipe_pkg::write_port_t      mem_write,
    output logic [`DATA_WIDTH-1:0]     operand1,
    output logic [`DATA_WIDTH-1:0]     operand2
);

    // The younger result in ex wins over mem, and both win over the file
    function automatic logic [`DATA_WIDTH-1:0] pick(
        input logic                          enable,
        input logic [`REG_ADDR_WIDTH-1:0]    addr,
        input logic [`DATA_WIDTH-1:0]        file_result,
        input logic [`DATA_WIDTH-1:0]        immediate,
        input pipe_pkg::write_port_t         ex_port,
        input pipe_pkg::write_port_t         mem_port
    );
        if (!enable) begin
            return immediate;
        end
        if (addr != '0 && ex_port.enable && ex_port.addr == addr) begin
            return ex_port.data;
        end
        if (addr != '0 && mem_port.enable && mem_port.addr == addr) begin
            return mem_port.data;
        end
        return file_result;
    endfunction

    assign operand1 = pick(rd.read_enable1, rd.read_addr1, rd.read_result1,
                           imm, ex_write, mem_write);
    assign operand2 = pick(rd.read_enable2, rd.read_addr2, rd.read_result2,
                           imm, ex_write, mem_write);

endmodule

// File: verilog/pipe_pkg.sv
`include "logic_core_defines.svh"

package pipe_pkg;

    // A pending register write, seen by forwarding and write-back
    typedef struct packed {
        logic                          enable;
        logic [`REG_ADDR_WIDTH-1:0]    addr;
        logic [`DATA_WIDTH-1:0]        data;
    } write_port_t;

    // Decoded instruction with its operands, handed to execution
    typedef struct packed {
        logic                          valid;
        isa_pkg::alu_op_t              op;
        logic [`DATA_WIDTH-1:0]        operand1;
        logic [`DATA_WIDTH-1:0]        operand2;
        logic                          write_enable;
        logic [`REG_ADDR_WIDTH-1:0]    write_addr;
    } exec_req_t;

endpackage

// File: verilog/reg_read_if.sv
`timescale 1ns/1ns
`include "logic_core_defines.svh"

interface reg_read_if;

    logic                          read_enable1;
    logic                          read_enable2;
    logic [`REG_ADDR_WIDTH-1:0]    read_addr1;
    logic [`REG_ADDR_WIDTH-1:0]    read_addr2;
    logic [`DATA_WIDTH-1:0]        read_result1;
    logic [`DATA_WIDTH-1:0]        read_result2;

    modport decoder (output read_enable1, read_enable2, read_addr1, read_addr2);

    modport file (input read_addr1, read_addr2, output read_result1, read_result2);

    modport select (
        input read_enable1, read_enable2, read_addr1, read_addr2,
        input read_result1, read_result2
    );

endinterface

// File: verilog/register_file.sv
`timescale 1ns/1ns
`include "logic_core_defines.svh"

module register_file (
    input  logic                   clk,
    input  logic                   reset,
    reg_read_if.file               rd,
    input  pipe_pkg::write_port_t  wr
);

    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.enable && wr.addr != '0) begin
            regs[wr.addr] <= wr.data;  // Register 0 is never written
        end
    end

    assign rd.read_result1 = (rd.read_addr1 == '0) ? '0 : regs[rd.read_addr1];
    assign rd.read_result2 = (rd.read_addr2 == '0) ? '0 : regs[rd.read_addr2];

endmodule
